//--- Bender.yml
package:
  name: pi_loop

sources:
  - files:
      - pi_loop_pkg.sv
      - cplx_gain_mul.sv
      - ki_integrator.sv
      - iq_pi_loop.sv
      - pi_cfg_regs.sv
      - pi_loop_top.sv
  - target: test
    files:
      - pi_loop_sva.sv
      - pi_loop_tb.sv

//--- cplx_gain_mul.sv
// Three-stage pipelined complex multiplier for the proportional gain stage
`timescale 1ns/1ps

module cplx_gain_mul
	import pi_loop_pkg::*;
#(
	parameter int KW = 18
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic signed [OUT_W-1:0] x_i_i,
	input  logic signed [OUT_W-1:0] x_q_i,
	input  logic signed [KW-1:0]    k_i_i,
	input  logic signed [KW-1:0]    k_q_i,
	output logic signed [OUT_W-1:0] z_i_o,
	output logic signed [OUT_W-1:0] z_q_o
);

	// Full product width, one more bit for the sum of two products
	localparam int PW = OUT_W + KW;

	logic signed [OUT_W-1:0] x_i_r, x_q_r;
	logic signed [KW-1:0]    k_i_r, k_q_r;
	logic signed [PW-1:0]    p_ii, p_qq, p_iq, p_qi;
	logic signed [PW:0]      sum_i, sum_q;
	logic signed [PW:0]      scl_i, scl_q;

	// Stage one, register signal and gain together
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			x_i_r <= '0;
			x_q_r <= '0;
			k_i_r <= '0;
			k_q_r <= '0;
		end else begin
			x_i_r <= x_i_i;
			x_q_r <= x_q_i;
			k_i_r <= k_i_i;
			k_q_r <= k_q_i;
		end
	end

	// Stage two, the four partial products
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			p_ii <= '0;
			p_qq <= '0;
			p_iq <= '0;
			p_qi <= '0;
		end else begin
			p_ii <= x_i_r * k_i_r;
			p_qq <= x_q_r * k_q_r;
			p_iq <= x_i_r * k_q_r;
			p_qi <= x_q_r * k_i_r;
		end
	end

	// (xI + j xQ)(kI + j kQ), gain is Q1.(KW-1) so drop KW-1 fraction bits
	always_comb begin
		sum_i = p_ii - p_qq;
		sum_q = p_iq + p_qi;
		scl_i = sum_i >>> (KW - 1);
		scl_q = sum_q >>> (KW - 1);
	end

	// Stage three, saturate into the output width
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			z_i_o <= '0;
			z_q_o <= '0;
		end else begin
			z_i_o <= sat_out(scl_i);
			z_q_o <= sat_out(scl_q);
		end
	end

endmodule

//--- iq_pi_loop.sv
// Complex PI loop datapath with error clamp, proportional gain, gating, integrators and output sum
`timescale 1ns/1ps

module iq_pi_loop
	import pi_loop_pkg::*;
#(
	parameter int KW = 18
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic signed [ERR_W-1:0] err_i_i,
	input  logic signed [ERR_W-1:0] err_q_i,
	input  logic signed [FF_W-1:0]  fdfwd_i_i,
	input  logic signed [FF_W-1:0]  fdfwd_q_i,
	input  logic                    integ_gate_i,
	input  logic                    integ_clr_i,
	input  logic signed [KW-1:0]    kp_i_i,
	input  logic signed [KW-1:0]    kp_q_i,
	input  logic signed [KW-1:0]    ki_over_kp_i,
	input  logic [3:0]              post_shift_i,
	input  logic                    feedback_en_i,
	output logic signed [OUT_W-1:0] pi_out_i_o,
	output logic signed [OUT_W-1:0] pi_out_q_o
);

	// Error keeps 14 significant bits, then moves up by 3
	localparam int CLAMP_W = 14;
	localparam int CLAMP_SH = 3;

	logic signed [ERR_W-1:0] i_err_r, q_err_r;
	logic signed [63:0]      i_err_sat, q_err_sat;
	logic signed [OUT_W-1:0] i_clamp, q_clamp;
	logic signed [OUT_W-1:0] i_clamp_r, q_clamp_r;
	logic signed [OUT_W-1:0] i_prop, q_prop;
	logic signed [OUT_W-1:0] i_prop_g, q_prop_g;
	logic signed [OUT_W-1:0] i_prop_d1, q_prop_d1;
	logic signed [OUT_W-1:0] i_prop_d2, q_prop_d2;
	logic signed [ACC_W-1:0] i_acc, q_acc;
	logic signed [OUT_W:0]   i_sum, q_sum;

	// Cycle 1, input register on the raw error
	// Cycle 2, register after the clamp
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			i_err_r <= '0;
			q_err_r <= '0;
			i_clamp_r <= '0;
			q_clamp_r <= '0;
		end else begin
			i_err_r <= err_i_i;
			q_err_r <= err_q_i;
			i_clamp_r <= i_clamp;
			q_clamp_r <= q_clamp;
		end
	end

	// Clamp to 14 bits, bit 14 of the widened result repeats the sign
	always_comb begin
		i_err_sat = sat_narrow(i_err_r, CLAMP_W);
		q_err_sat = sat_narrow(q_err_r, CLAMP_W);
		i_clamp = {i_err_sat[OUT_W-CLAMP_SH-1:0], {CLAMP_SH{1'b0}}};
		q_clamp = {q_err_sat[OUT_W-CLAMP_SH-1:0], {CLAMP_SH{1'b0}}};
	end

	// Cycles 3 to 5, proportional gain
	cplx_gain_mul #(.KW(KW)) u_prop_mul (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.x_i_i   (i_clamp_r),
		.x_q_i   (q_clamp_r),
		.k_i_i   (kp_i_i),
		.k_q_i   (kp_q_i),
		.z_i_o   (i_prop),
		.z_q_o   (q_prop)
	);

	// Feedback off removes the proportional term from both paths
	assign i_prop_g = feedback_en_i ? i_prop : '0;
	assign q_prop_g = feedback_en_i ? q_prop : '0;

	// Cycles 6 and 7, integrators
	// Feedforward enters the integrator with no extra delay
	ki_integrator #(.KW(KW)) u_integ_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.gate_i  (integ_gate_i),
		.clr_i   (integ_clr_i),
		.ki_i    (ki_over_kp_i),
		.shift_i (post_shift_i),
		.sig_i   (i_prop_g),
		.fdfwd_i (fdfwd_i_i),
		.acc_o   (i_acc)
	);

	ki_integrator #(.KW(KW)) u_integ_q (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.gate_i  (integ_gate_i),
		.clr_i   (integ_clr_i),
		.ki_i    (ki_over_kp_i),
		.shift_i (post_shift_i),
		.sig_i   (q_prop_g),
		.fdfwd_i (fdfwd_q_i),
		.acc_o   (q_acc)
	);

	// Proportional term waits 2 cycles to line up with the accumulator
	// Cycle 8 adds acc[20:3], cycle 9 saturates
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			i_prop_d1 <= '0;
			q_prop_d1 <= '0;
			i_prop_d2 <= '0;
			q_prop_d2 <= '0;
			i_sum <= '0;
			q_sum <= '0;
			pi_out_i_o <= '0;
			pi_out_q_o <= '0;
		end else begin
			i_prop_d1 <= i_prop_g;
			q_prop_d1 <= q_prop_g;
			i_prop_d2 <= i_prop_d1;
			q_prop_d2 <= q_prop_d1;
			i_sum <= $signed(i_acc[ACC_W-1:3]) + i_prop_d2;
			q_sum <= $signed(q_acc[ACC_W-1:3]) + q_prop_d2;
			pi_out_i_o <= sat_out(i_sum);
			pi_out_q_o <= sat_out(q_sum);
		end
	end

endmodule

//--- ki_integrator.sv
// Two-stage Ki/Kp scaling and saturating integrator with feedforward for one channel
`timescale 1ns/1ps

module ki_integrator
	import pi_loop_pkg::*;
#(
	parameter int KW = 18
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    gate_i,
	input  logic                    clr_i,
	input  logic signed [KW-1:0]    ki_i,
	input  logic [3:0]              shift_i,
	input  logic signed [OUT_W-1:0] sig_i,
	input  logic signed [FF_W-1:0]  fdfwd_i,
	output logic signed [ACC_W-1:0] acc_o
);

	// Product width and width of the scaled increment
	localparam int PW = OUT_W + KW;
	localparam int IW = OUT_W + 1;

	logic signed [PW-1:0]    prod;
	logic signed [PW-1:0]    shifted;
	logic signed [IW-1:0]    inc_r;
	logic signed [FF_W-1:0]  ff_r;
	logic signed [ACC_W+1:0] sum;
	logic signed [63:0]      sat_wide;
	logic signed [ACC_W-1:0] acc_next;
	logic signed [ACC_W-1:0] acc_r;

	// Ki/Kp is a Q1.(KW-1) fraction, then the extra post shift
	always_comb begin
		prod = sig_i * ki_i;
		shifted = (prod >>> (KW - 1)) >>> shift_i;
	end

	// Stage one, scaled increment and feedforward registered side by side
	// Result fits in OUT_W+1 bits even for min times min
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			inc_r <= '0;
			ff_r <= '0;
		end else begin
			inc_r <= shifted[IW-1:0];
			ff_r <= fdfwd_i;
		end
	end

	// Two guard bits cover acc + increment + feedforward
	always_comb begin
		sum = acc_r + inc_r + ff_r;
		sat_wide = sat_narrow(sum, ACC_W);
		acc_next = sat_wide[ACC_W-1:0];
	end

	// Stage two, accumulate
	// Clear wins over the gate, gate low holds the value
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			acc_r <= '0;
		else if (clr_i)
			acc_r <= '0;
		else if (gate_i)
			acc_r <= acc_next;
	end

	assign acc_o = acc_r;

endmodule

//--- pi_cfg_regs.sv
// Configuration registers for loop gains, post shift and feedback enable with readback
`timescale 1ns/1ps

module pi_cfg_regs
	import pi_loop_pkg::*;
#(
	parameter int KW = 18
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 cfg_we_i,
	input  logic [CFG_AW-1:0]    cfg_addr_i,
	input  logic [31:0]          cfg_wdata_i,
	output logic [31:0]          cfg_rdata_o,
	output logic signed [KW-1:0] kp_i_o,
	output logic signed [KW-1:0] kp_q_o,
	output logic signed [KW-1:0] ki_over_kp_o,
	output logic [3:0]           post_shift_o,
	output logic                 feedback_en_o
);

	cfg_addr_e           addr;
	logic signed [KW-1:0] kp_i_r, kp_q_r, ki_r;
	logic [3:0]           shift_r;
	logic                 fb_en_r;

	assign addr = cfg_addr_e'(cfg_addr_i);

	// Write on the strobe edge, low bits of the data word only
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			kp_i_r <= '0;
			kp_q_r <= '0;
			ki_r <= '0;
			shift_r <= '0;
			fb_en_r <= 1'b0;
		end else if (cfg_we_i) begin
			case (addr)
				CFG_KP_I:  kp_i_r <= cfg_wdata_i[KW-1:0];
				CFG_KP_Q:  kp_q_r <= cfg_wdata_i[KW-1:0];
				CFG_KI:    ki_r <= cfg_wdata_i[KW-1:0];
				CFG_SHIFT: shift_r <= cfg_wdata_i[3:0];
				CFG_CTRL:  fb_en_r <= cfg_wdata_i[0];
				// Holes in the map drop the write
				default: ;
			endcase
		end
	end

	// Readback mux, gains come back zero extended
	always_comb begin
		cfg_rdata_o = '0;
		case (addr)
			CFG_KP_I:  cfg_rdata_o[KW-1:0] = kp_i_r;
			CFG_KP_Q:  cfg_rdata_o[KW-1:0] = kp_q_r;
			CFG_KI:    cfg_rdata_o[KW-1:0] = ki_r;
			CFG_SHIFT: cfg_rdata_o[3:0] = shift_r;
			CFG_CTRL:  cfg_rdata_o[0] = fb_en_r;
			default:   cfg_rdata_o = '0;
		endcase
	end

	// Levels to the loop
	assign kp_i_o = kp_i_r;
	assign kp_q_o = kp_q_r;
	assign ki_over_kp_o = ki_r;
	assign post_shift_o = shift_r;
	assign feedback_en_o = fb_en_r;

endmodule

//--- pi_loop_pkg.sv
// Width constants, configuration register addresses and saturation functions for the PI loop
package pi_loop_pkg;

	// Error input width, clamped inside the loop
	localparam int ERR_W = 19;
	// Feedforward input width
	localparam int FF_W = 17;
	// Output width, also the width of the proportional term
	localparam int OUT_W = 18;
	// Integrator accumulator width
	localparam int ACC_W = 21;
	// Configuration address width
	localparam int CFG_AW = 3;

	// Register map, one 32-bit word per address
	typedef enum logic [CFG_AW-1:0] {
		CFG_KP_I  = 3'd0,
		CFG_KP_Q  = 3'd1,
		CFG_KI    = 3'd2,
		CFG_SHIFT = 3'd3,
		CFG_CTRL  = 3'd4
	} cfg_addr_e;

	// Saturate x to a signed w-bit range, result is sign extended to 64 bits
	// Values that fit are kept, the rest rail to the max or min of w bits
	function automatic logic signed [63:0] sat_narrow(input logic signed [63:0] x,
			input int w);
		logic signed [63:0] hi;
		logic signed [63:0] lo;
		hi = (64'sd1 <<< (w - 1)) - 64'sd1;
		lo = -(64'sd1 <<< (w - 1));
		if (x > hi)
			sat_narrow = hi;
		else if (x < lo)
			sat_narrow = lo;
		else
			sat_narrow = x;
	endfunction

	// Shorthand for saturation to the output width
	function automatic logic signed [OUT_W-1:0] sat_out(input logic signed [63:0] x);
		logic signed [63:0] s;
		s = sat_narrow(x, OUT_W);
		sat_out = s[OUT_W-1:0];
	endfunction

endpackage

//--- pi_loop_sva.sv
// Bound assertions for the PI loop: reset state, clamp range and integrator clear
`timescale 1ns/1ps

module pi_loop_sva
	import pi_loop_pkg::*;
(
	input logic                    clk,
	input logic                    rst_n_i,
	input logic signed [OUT_W-1:0] i_clamp,
	input logic signed [OUT_W-1:0] q_clamp,
	input logic                    integ_gate_i,
	input logic                    integ_clr_i,
	input logic signed [ACC_W-1:0] i_acc,
	input logic signed [ACC_W-1:0] q_acc,
	input logic signed [OUT_W-1:0] pi_out_i_o,
	input logic signed [OUT_W-1:0] pi_out_q_o
);

	// Number of assertion failures so far
	int fail_cnt = 0;

	// Synchronous reset, outputs are zero right after the reset edge
	a_reset_out: assert property (@(posedge clk)
		!rst_n_i |=> (pi_out_i_o == '0 && pi_out_q_o == '0))
		else begin
			$error("outputs not zero after reset");
			fail_cnt++;
		end

	// 14 significant bits shifted up by 3
	a_clamp_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		(i_clamp >= -65536 && i_clamp <= 65528 &&
		 q_clamp >= -65536 && q_clamp <= 65528))
		else begin
			$error("clamped error out of range");
			fail_cnt++;
		end

	// Clear with the gate low empties both accumulators
	a_clear_acc: assert property (@(posedge clk) disable iff (!rst_n_i)
		(integ_clr_i && !integ_gate_i) |=> (i_acc == '0 && q_acc == '0))
		else begin
			$error("accumulator not zero after clear");
			fail_cnt++;
		end

endmodule

bind iq_pi_loop pi_loop_sva u_sva (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.i_clamp      (i_clamp),
	.q_clamp      (q_clamp),
	.integ_gate_i (integ_gate_i),
	.integ_clr_i  (integ_clr_i),
	.i_acc        (i_acc),
	.q_acc        (q_acc),
	.pi_out_i_o   (pi_out_i_o),
	.pi_out_q_o   (pi_out_q_o)
);

//--- pi_loop_tb.sv
// Testbench for the PI loop top level: stimulus, reference model, comparison and watchdog
`timescale 1ns/1ps

module pi_loop_tb
	import pi_loop_pkg::*;
;
	localparam int KW = 18;
	localparam int N_STREAM = 300;
	localparam int N_SAT = 200;
	localparam int N_RAMP = 150;
	localparam int N_GATE = 100;
	localparam int N_FULL = 300;
	localparam int ROUNDS = 3;
	// Each loop configuration costs two quiet windows plus the writes
	localparam int CFG_CYCLES = 40;
	localparam int STIM_CYCLES = 16 + 120 + N_STREAM + N_SAT + N_RAMP + N_GATE +
		ROUNDS * N_FULL + 8 * CFG_CYCLES + 20;
	localparam int WATCHDOG_CYCLES = STIM_CYCLES + 200;

	logic clk;
	logic rst_n_i;
	logic cfg_we_i;
	logic [CFG_AW-1:0] cfg_addr_i;
	logic [31:0] cfg_wdata_i;
	logic [31:0] cfg_rdata_o;
	logic signed [ERR_W-1:0] err_i_i, err_q_i;
	logic signed [FF_W-1:0] fdfwd_i_i, fdfwd_q_i;
	logic integ_gate_i, integ_clr_i;
	logic signed [OUT_W-1:0] pi_out_i_o, pi_out_q_o;

	integer seed = 66;
	int err_cnt = 0;
	int sva_cnt;
	// Shadow of the register block as written by the testbench
	longint kp_i_s = 0, kp_q_s = 0, ki_s = 0, shift_s = 0, fb_s = 0;
	// Model history, index k is k cycles back
	longint e_i_h[0:4], e_q_h[0:4], g_i_h[0:4], g_q_h[0:4];
	longint acc_i_h[0:2], acc_q_h[0:2];
	longint ff_i_prev, ff_q_prev, exp_i, exp_q;
	bit model_on = 0;

	pi_loop_top #(.KW(KW)) pi_loop_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Own saturation for the model
	function automatic longint clip(input longint x, input int w);
		longint hi, lo;
		hi = (64'sd1 <<< (w - 1)) - 1;
		lo = -(64'sd1 <<< (w - 1));
		return (x > hi) ? hi : ((x < lo) ? lo : x);
	endfunction

	function automatic longint scale_inc(input longint g);
		return ((g * ki_s) >>> (KW - 1)) >>> shift_s;
	endfunction

	// Expected output from the accumulator and the aligned proportional term
	function automatic longint pi_ref(input longint acc, input longint prop);
		return clip((acc >>> 3) + prop, OUT_W);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
		if (got !== expv) begin
			err_cnt++;
			$display("ERR %s got %h exp %h at %0t", name, got, expv, $time);
		end
	endtask

	// Model advances on each rising edge with the inputs just sampled
	always @(posedge clk) begin
		longint p_i, p_q, a_i, a_q;
		model_on <= 1'b1;
		if (!rst_n_i) begin
			for (int k = 0; k < 5; k++) begin
				e_i_h[k] = 0;
				e_q_h[k] = 0;
				g_i_h[k] = 0;
				g_q_h[k] = 0;
			end
			for (int k = 0; k < 3; k++) begin
				acc_i_h[k] = 0;
				acc_q_h[k] = 0;
			end
			ff_i_prev = 0;
			ff_q_prev = 0;
			exp_i = 0;
			exp_q = 0;
		end else begin
			for (int k = 4; k > 0; k--) begin
				e_i_h[k] = e_i_h[k-1];
				e_q_h[k] = e_q_h[k-1];
				g_i_h[k] = g_i_h[k-1];
				g_q_h[k] = g_q_h[k-1];
			end
			e_i_h[0] = clip(err_i_i, 14) * 8;
			e_q_h[0] = clip(err_q_i, 14) * 8;
			// Complex product with a Q1.17 gain
			p_i = clip((e_i_h[4] * kp_i_s - e_q_h[4] * kp_q_s) >>> (KW - 1), OUT_W);
			p_q = clip((e_i_h[4] * kp_q_s + e_q_h[4] * kp_i_s) >>> (KW - 1), OUT_W);
			g_i_h[0] = fb_s ? p_i : 0;
			g_q_h[0] = fb_s ? p_q : 0;
			a_i = acc_i_h[0];
			a_q = acc_q_h[0];
			if (integ_clr_i) begin
				a_i = 0;
				a_q = 0;
			end else if (integ_gate_i) begin
				a_i = clip(acc_i_h[0] + scale_inc(g_i_h[2]) + ff_i_prev, ACC_W);
				a_q = clip(acc_q_h[0] + scale_inc(g_q_h[2]) + ff_q_prev, ACC_W);
			end
			for (int k = 2; k > 0; k--) begin
				acc_i_h[k] = acc_i_h[k-1];
				acc_q_h[k] = acc_q_h[k-1];
			end
			acc_i_h[0] = a_i;
			acc_q_h[0] = a_q;
			ff_i_prev = fdfwd_i_i;
			ff_q_prev = fdfwd_q_i;
			exp_i = pi_ref(acc_i_h[2], g_i_h[4]);
			exp_q = pi_ref(acc_q_h[2], g_q_h[4]);
		end
	end

	// Outputs are compared mid-cycle
	always @(negedge clk) begin
		if (model_on) begin
			check("pi_out_i_o", pi_out_i_o, 32'(exp_i));
			check("pi_out_q_o", pi_out_q_o, 32'(exp_q));
		end
	end

	task automatic step(input longint ei, input longint eq, input longint fi,
			input longint fq, input bit gate, input bit clr);
		@(negedge clk);
		err_i_i = ei;
		err_q_i = eq;
		fdfwd_i_i = fi;
		fdfwd_q_i = fq;
		integ_gate_i = gate;
		integ_clr_i = clr;
	endtask

	task automatic quiet(input int n);
		repeat (n) step(0, 0, 0, 0, 1'b0, 1'b1);
	endtask

	task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [31:0] data);
		logic signed [KW-1:0] g;
		@(negedge clk);
		cfg_we_i = 1'b1;
		cfg_addr_i = addr;
		cfg_wdata_i = data;
		g = data[KW-1:0];
		case (addr)
			CFG_KP_I:  kp_i_s = g;
			CFG_KP_Q:  kp_q_s = g;
			CFG_KI:    ki_s = g;
			CFG_SHIFT: shift_s = data[3:0];
			CFG_CTRL:  fb_s = data[0];
			default: ;
		endcase
		@(negedge clk);
		cfg_we_i = 1'b0;
	endtask

	task automatic cfg_read(input logic [CFG_AW-1:0] addr, input logic [31:0] expv);
		@(negedge clk);
		cfg_addr_i = addr;
		@(posedge clk);
		check("cfg_rdata_o", cfg_rdata_o, expv);
	endtask

	// Config changes only while the pipeline is flushed and cleared
	task automatic set_cfg(input longint kpi, input longint kpq, input longint ki,
			input longint sh, input bit fb);
		quiet(12);
		cfg_write(CFG_KP_I, 32'(kpi));
		cfg_write(CFG_KP_Q, 32'(kpq));
		cfg_write(CFG_KI, 32'(ki));
		cfg_write(CFG_SHIFT, 32'(sh));
		cfg_write(CFG_CTRL, 32'(fb));
		quiet(12);
	endtask

	initial begin
		rst_n_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		err_i_i = '0;
		err_q_i = '0;
		fdfwd_i_i = '0;
		fdfwd_q_i = '0;
		integ_gate_i = 1'b0;
		integ_clr_i = 1'b1;
		repeat (16) @(negedge clk);
		rst_n_i = 1'b1;
		quiet(4);
		// Register write and readback, holes read zero
		cfg_write(CFG_KP_I, 32'h0003_1234);
		cfg_write(CFG_KP_Q, 32'hFFFE_ABCD);
		cfg_write(CFG_KI, 32'h0001_5555);
		cfg_write(CFG_SHIFT, 32'h0000_00A7);
		cfg_write(CFG_CTRL, 32'h0000_0003);
		for (int a = 5; a < 8; a++)
			cfg_write(a, 32'hFFFF_FFFF);
		cfg_read(CFG_KP_I, 32'h0003_1234);
		cfg_read(CFG_KP_Q, 32'h0002_ABCD);
		cfg_read(CFG_KI, 32'h0001_5555);
		cfg_read(CFG_SHIFT, 32'h0000_0007);
		cfg_read(CFG_CTRL, 32'h0000_0001);
		for (int a = 5; a < 8; a++)
			cfg_read(a, 32'h0);
		check("kp_i", pi_loop_top_i.kp_i, 32'(kp_i_s));
		check("kp_q", pi_loop_top_i.kp_q, 32'(kp_q_s));
		check("ki_over_kp", pi_loop_top_i.ki_over_kp, 32'(ki_s));
		// Proportional path only, integrator held clear
		set_cfg(20000, -15000, 0, 0, 1'b1);
		repeat (N_STREAM) step($random(seed), $random(seed), 0, 0, 1'b0, 1'b1);
		// Big errors and gains, integrator pushes the sum into the rails
		set_cfg(131071, -131072, 131071, 0, 1'b1);
		step(262143, -262144, 0, 0, 1'b1, 1'b0);
		step(-262144, 262143, 0, 0, 1'b1, 1'b0);
		repeat (N_SAT - 2) step($random(seed), $random(seed), 65535, -65536, 1'b1, 1'b0);
		// Feedforward ramp with feedback off
		set_cfg(40000, 0, 50000, 0, 1'b0);
		repeat (N_RAMP) step($random(seed), $random(seed), 20000, -7000, 1'b1, 1'b0);
		// Gate freeze and clear
		set_cfg(30000, 5000, 8000, 2, 1'b1);
		repeat (40) step(1000, -500, 3000, 1000, 1'b1, 1'b0);
		repeat (20) step(1000, -500, 3000, 1000, 1'b0, 1'b0);
		repeat (3) step(1000, -500, 3000, 1000, 1'b0, 1'b1);
		repeat (N_GATE - 63) step(1000, -500, 3000, 1000, 1'b1, 1'b0);
		// Full loop with random settings
		for (int r = 0; r < ROUNDS; r++) begin
			set_cfg($random(seed), $random(seed), $random(seed), $random(seed) & 15, 1'b1);
			repeat (N_FULL)
				step($random(seed), $random(seed), ($random(seed) % 16384),
					($random(seed) % 16384), ($random(seed) & 3) != 0,
					($random(seed) & 63) == 0);
		end
		quiet(20);
		sva_cnt = pi_loop_top_i.u_loop.u_sva.fail_cnt;
		$display("Checks done with %0d errors and %0d assertion failures",
			err_cnt, sva_cnt);
		if (err_cnt == 0 && sva_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("Timeout: the run did not reach its end in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- pi_loop_top.sv
// Top level joining the configuration registers and the complex PI loop
`timescale 1ns/1ps

module pi_loop_top
	import pi_loop_pkg::*;
#(
	parameter int KW = 18
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    cfg_we_i,
	input  logic [CFG_AW-1:0]       cfg_addr_i,
	input  logic [31:0]             cfg_wdata_i,
	output logic [31:0]             cfg_rdata_o,
	input  logic signed [ERR_W-1:0] err_i_i,
	input  logic signed [ERR_W-1:0] err_q_i,
	input  logic signed [FF_W-1:0]  fdfwd_i_i,
	input  logic signed [FF_W-1:0]  fdfwd_q_i,
	input  logic                    integ_gate_i,
	input  logic                    integ_clr_i,
	output logic signed [OUT_W-1:0] pi_out_i_o,
	output logic signed [OUT_W-1:0] pi_out_q_o
);

	// Register block outputs, static between writes
	logic signed [KW-1:0] kp_i, kp_q, ki_over_kp;
	logic [3:0]           post_shift;
	logic                 feedback_en;

	pi_cfg_regs #(.KW(KW)) u_cfg (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cfg_we_i      (cfg_we_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_wdata_i   (cfg_wdata_i),
		.cfg_rdata_o   (cfg_rdata_o),
		.kp_i_o        (kp_i),
		.kp_q_o        (kp_q),
		.ki_over_kp_o  (ki_over_kp),
		.post_shift_o  (post_shift),
		.feedback_en_o (feedback_en)
	);

	// 9 cycles from error in to PI out
	iq_pi_loop #(.KW(KW)) u_loop (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.err_i_i       (err_i_i),
		.err_q_i       (err_q_i),
		.fdfwd_i_i     (fdfwd_i_i),
		.fdfwd_q_i     (fdfwd_q_i),
		.integ_gate_i  (integ_gate_i),
		.integ_clr_i   (integ_clr_i),
		.kp_i_i        (kp_i),
		.kp_q_i        (kp_q),
		.ki_over_kp_i  (ki_over_kp),
		.post_shift_i  (post_shift),
		.feedback_en_i (feedback_en),
		.pi_out_i_o    (pi_out_i_o),
		.pi_out_q_o    (pi_out_q_o)
	);

endmodule

//--- vlog.f
pi_loop_pkg.sv
cplx_gain_mul.sv
ki_integrator.sv
iq_pi_loop.sv
pi_cfg_regs.sv
pi_loop_top.sv
pi_loop_sva.sv
pi_loop_tb.sv
